// File: rtl/ctrl_params.svh
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

//////////////////////////////
// instruction word layout
//////////////////////////////

// opcode       [15:12]
// dst / cond   [11:8]
// src0         [7:4]
// src1         [3:0]

`define CTRL_INSTR_W 16   // full instruction word

`define CTRL_OP_W 4       // opcode field

`define CTRL_COND_W 3     // branch condition, low bits of the dst field

`define CTRL_REG_W 4      // register address, 16 registers

`endif

// File: rtl/ctrl_pkg.sv
`default_nettype none

`include "ctrl_params.svh"

package ctrl_pkg;

   // opcode field encodings
   typedef enum logic [`CTRL_OP_W-1:0] {
      ADD  = 4'h0,
      SUB  = 4'h1,
      NAND = 4'h2,
      XOR  = 4'h3,
      INC  = 4'h4,
      SRA  = 4'h5,
      SRL  = 4'h6,
      SLL  = 4'h7,
      LW   = 4'h8,
      SW   = 4'h9,
      LHB  = 4'ha,
      LLB  = 4'hb,
      B    = 4'hc,
      CALL = 4'hd,   // decodes as no-op
      RET  = 4'he,   // decodes as no-op
      CMP  = 4'hf
   } opcode_t;

   // ALU operand mux
   typedef enum logic [2:0] {
      SRC_NONE,
      SRC_REG_REG,
      SRC_REG_IMM_S,    // signed immediate, INC
      SRC_REG_IMM,      // shift amount
      SRC_LOAD_ADDR,
      SRC_STORE_ADDR
   } alu_src_t;

   // write-back data source
   typedef enum logic [1:0] {DST_ALU, DST_IMM_BYTE, DST_MEM} dst_src_t;

   // branch conditions
   typedef enum logic [`CTRL_COND_W-1:0] {
      EQ   = 3'd0,
      LT   = 3'd1,
      GT   = 3'd2,
      OV   = 3'd3,
      NE   = 3'd4,
      GE   = 3'd5,
      LE   = 3'd6,
      TRUE = 3'd7
   } cond_t;

   // kind of result an instruction writes back
   typedef enum logic [1:0] {CLASS_NONE, CLASS_ALU, CLASS_IMM, CLASS_LOAD} op_class_t;

   // operand forward source per read port
   typedef enum logic [3:0] {
      FWD_NONE,
      FWD_EX_ALU, FWD_MEM_ALU, FWD_WB_ALU,
      FWD_EX_IMM, FWD_MEM_IMM, FWD_WB_IMM,
      FWD_MEM_LOAD, FWD_WB_LOAD
   } fwd_sel_t;

endpackage

`default_nettype wire

// File: rtl/instr_decoder.sv
`default_nettype none

`include "ctrl_params.svh"

module instr_decoder (
   input  wire logic [`CTRL_INSTR_W-1:0] instr,
   output logic                       reg_we,
   output logic                       rd0_en,
   output logic                       rd1_en,
   output logic [`CTRL_REG_W-1:0]     rd0_addr,
   output logic [`CTRL_REG_W-1:0]     rd1_addr,
   output logic [`CTRL_REG_W-1:0]     dst_addr,
   output ctrl_pkg::alu_src_t         alu_src,
   output ctrl_pkg::dst_src_t         dst_src,
   output logic                       imm_high,
   output logic                       dm_we,
   output logic                       dm_re,
   output logic                       flag_en,
   output logic                       is_branch,
   output ctrl_pkg::op_class_t        op_class,
   output ctrl_pkg::cond_t            cond
);

   localparam int OP_LSB   = `CTRL_INSTR_W - `CTRL_OP_W;   // 12
   localparam int DST_LSB  = 2 * `CTRL_REG_W;              // 8
   localparam int SRC0_LSB = `CTRL_REG_W;                  // 4

   ctrl_pkg::opcode_t        op;
   logic [`CTRL_REG_W-1:0]   dst_field;
   logic [`CTRL_REG_W-1:0]   src0;
   logic [`CTRL_REG_W-1:0]   src1;

   //////////////////////////////
   // field extraction
   //////////////////////////////

   assign op        = ctrl_pkg::opcode_t'(instr[OP_LSB +: `CTRL_OP_W]);
   assign dst_field = instr[DST_LSB +: `CTRL_REG_W];
   assign src0      = instr[SRC0_LSB +: `CTRL_REG_W];
   assign src1      = instr[`CTRL_REG_W-1:0];

   assign dst_addr = dst_field;
   assign cond     = ctrl_pkg::cond_t'(instr[DST_LSB +: `CTRL_COND_W]);   // bits 10:8

   //////////////////////////////
   // opcode decode
   //////////////////////////////

   always_comb begin
      reg_we    = 1'b0;
      rd0_en    = 1'b0;
      rd1_en    = 1'b0;
      rd0_addr  = src0;
      rd1_addr  = src1;
      alu_src   = ctrl_pkg::SRC_NONE;
      dst_src   = ctrl_pkg::DST_ALU;
      imm_high  = 1'b0;
      dm_we     = 1'b0;
      dm_re     = 1'b0;
      flag_en   = 1'b0;
      is_branch = 1'b0;
      op_class  = ctrl_pkg::CLASS_NONE;

      case (op)
         ctrl_pkg::ADD, ctrl_pkg::SUB, ctrl_pkg::NAND, ctrl_pkg::XOR: begin
            rd0_en   = 1'b1;
            rd1_en   = 1'b1;
            alu_src  = ctrl_pkg::SRC_REG_REG;
            reg_we   = 1'b1;
            op_class = ctrl_pkg::CLASS_ALU;
            flag_en  = 1'b1;
         end
         ctrl_pkg::CMP: begin   // flags only, no write-back
            rd0_en  = 1'b1;
            rd1_en  = 1'b1;
            alu_src = ctrl_pkg::SRC_REG_REG;
            flag_en = 1'b1;
         end
         ctrl_pkg::INC: begin
            rd1_en   = 1'b1;
            rd1_addr = dst_field;   // increments dst in place
            alu_src  = ctrl_pkg::SRC_REG_IMM_S;
            reg_we   = 1'b1;
            op_class = ctrl_pkg::CLASS_ALU;
            flag_en  = 1'b1;
         end
         ctrl_pkg::SRA, ctrl_pkg::SRL, ctrl_pkg::SLL: begin
            rd0_en   = 1'b1;
            alu_src  = ctrl_pkg::SRC_REG_IMM;
            reg_we   = 1'b1;
            op_class = ctrl_pkg::CLASS_ALU;
         end
         ctrl_pkg::LW: begin
            rd0_en   = 1'b1;   // base
            alu_src  = ctrl_pkg::SRC_LOAD_ADDR;
            reg_we   = 1'b1;
            dst_src  = ctrl_pkg::DST_MEM;
            dm_re    = 1'b1;
            op_class = ctrl_pkg::CLASS_LOAD;
         end
         ctrl_pkg::SW: begin
            rd0_en   = 1'b1;        // base
            rd1_en   = 1'b1;
            rd1_addr = dst_field;   // store data
            alu_src  = ctrl_pkg::SRC_STORE_ADDR;
            dm_we    = 1'b1;
         end
         ctrl_pkg::LHB, ctrl_pkg::LLB: begin
            // the untouched byte comes from the old dst value
            rd1_en   = 1'b1;
            rd1_addr = dst_field;
            reg_we   = 1'b1;
            dst_src  = ctrl_pkg::DST_IMM_BYTE;
            imm_high = (op == ctrl_pkg::LHB);
            op_class = ctrl_pkg::CLASS_IMM;
         end
         ctrl_pkg::B: begin
            is_branch = 1'b1;
         end
         default: ;   // CALL and RET are no-ops
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/flag_branch_unit.sv
`default_nettype none

module flag_branch_unit (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire logic            n,         // EX result flags
   input  wire logic            z,
   input  wire logic            v,
   input  wire logic            flag_en,
   input  wire logic            is_branch,
   input  wire ctrl_pkg::cond_t cond,
   input  wire logic            stall,
   output logic                 n_flag,
   output logic                 z_flag,
   output logic                 v_flag,
   output logic                 branch_taken,
   output logic                 branch_wait
);

   logic flag_pending;   // instruction in ID/EX will update the flags
   logic cond_met;

   //////////////////////////////
   // flag register
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         flag_pending <= 1'b0;
         n_flag       <= 1'b0;
         z_flag       <= 1'b0;
         v_flag       <= 1'b0;
      end else begin
         // a stall puts a bubble into ID/EX, which never sets flags
         flag_pending <= flag_en & ~stall;
         if (flag_pending) begin
            n_flag <= n;
            z_flag <= z;
            v_flag <= v;
         end
      end
   end

   // flags are one cycle from valid while a setter sits in EX
   assign branch_wait = is_branch & flag_pending;

   //////////////////////////////
   // branch conditions
   //////////////////////////////

   always_comb begin
      case (cond)
         ctrl_pkg::EQ: cond_met = z_flag;
         ctrl_pkg::LT: cond_met = n_flag & ~v_flag;
         ctrl_pkg::GT: cond_met = ~(n_flag | v_flag | z_flag);
         ctrl_pkg::OV: cond_met = v_flag;
         ctrl_pkg::NE: cond_met = ~z_flag;
         ctrl_pkg::GE: cond_met = z_flag | ~(n_flag | v_flag);
         ctrl_pkg::LE: cond_met = z_flag | (n_flag & ~v_flag);
         default:      cond_met = 1'b1;   // TRUE
      endcase
   end

   // unconditional branches need no flags and never wait on them
   assign branch_taken = is_branch & cond_met &
                         (~flag_pending | (cond == ctrl_pkg::TRUE));

   // the wait stalls the pipe, so the setter leaves EX next cycle
   a_wait_one_cycle: assert property (@(posedge clk) disable iff (rst)
      branch_wait |=> !branch_wait)
      else $error("branch waited more than one cycle on flags");

endmodule

`default_nettype wire

// File: rtl/stage_tracker.sv
`default_nettype none

`include "ctrl_params.svh"

module stage_tracker (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire logic                      stall,
   input  wire ctrl_pkg::op_class_t       op_class,
   input  wire logic [`CTRL_REG_W-1:0]    dst_addr,
   output ctrl_pkg::op_class_t            ex_class,
   output ctrl_pkg::op_class_t            mem_class,
   output ctrl_pkg::op_class_t            wb_class,
   output logic [`CTRL_REG_W-1:0]         ex_dst,
   output logic [`CTRL_REG_W-1:0]         mem_dst,
   output logic [`CTRL_REG_W-1:0]         wb_dst
);

   //////////////////////////////
   // result class chain
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_class  <= ctrl_pkg::CLASS_NONE;
         mem_class <= ctrl_pkg::CLASS_NONE;
         wb_class  <= ctrl_pkg::CLASS_NONE;
      end else begin
         ex_class  <= stall ? ctrl_pkg::CLASS_NONE : op_class;   // bubble on stall
         mem_class <= ex_class;
         wb_class  <= mem_class;
      end
   end

   // destination chain, only meaningful where the class is not none
   always_ff @(posedge clk) begin
      ex_dst  <= dst_addr;
      mem_dst <= ex_dst;
      wb_dst  <= mem_dst;
   end

endmodule

`default_nettype wire

// File: rtl/forward_select.sv
`default_nettype none

`include "ctrl_params.svh"

module forward_select (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire logic                      rd0_en,
   input  wire logic                      rd1_en,
   input  wire logic [`CTRL_REG_W-1:0]    rd0_addr,
   input  wire logic [`CTRL_REG_W-1:0]    rd1_addr,
   input  wire ctrl_pkg::op_class_t       ex_class,
   input  wire ctrl_pkg::op_class_t       mem_class,
   input  wire ctrl_pkg::op_class_t       wb_class,
   input  wire logic [`CTRL_REG_W-1:0]    ex_dst,
   input  wire logic [`CTRL_REG_W-1:0]    mem_dst,
   input  wire logic [`CTRL_REG_W-1:0]    wb_dst,
   input  wire logic                      branch_wait,
   output logic                           stall,
   output ctrl_pkg::fwd_sel_t             fwd_p0_sel,
   output ctrl_pkg::fwd_sel_t             fwd_p1_sel
);

   ctrl_pkg::fwd_sel_t p0_sel;
   ctrl_pkg::fwd_sel_t p1_sel;
   logic               p0_load_use;
   logic               p1_load_use;

   //////////////////////////////
   // hazard compare
   //////////////////////////////

   // nearest stage wins, ID/EX first
   function automatic ctrl_pkg::fwd_sel_t lookup(input logic en,
                                                 input logic [`CTRL_REG_W-1:0] addr);
      ctrl_pkg::fwd_sel_t sel;
      sel = ctrl_pkg::FWD_NONE;
      if (!en) begin
         sel = ctrl_pkg::FWD_NONE;
      end else if (ex_class != ctrl_pkg::CLASS_NONE && ex_dst == addr) begin
         if (ex_class == ctrl_pkg::CLASS_ALU)
            sel = ctrl_pkg::FWD_EX_ALU;
         else if (ex_class == ctrl_pkg::CLASS_IMM)
            sel = ctrl_pkg::FWD_EX_IMM;   // load here is a stall, not a forward
      end else if (mem_class != ctrl_pkg::CLASS_NONE && mem_dst == addr) begin
         case (mem_class)
            ctrl_pkg::CLASS_ALU: sel = ctrl_pkg::FWD_MEM_ALU;
            ctrl_pkg::CLASS_IMM: sel = ctrl_pkg::FWD_MEM_IMM;
            default:             sel = ctrl_pkg::FWD_MEM_LOAD;
         endcase
      end else if (wb_class != ctrl_pkg::CLASS_NONE && wb_dst == addr) begin
         case (wb_class)
            ctrl_pkg::CLASS_ALU: sel = ctrl_pkg::FWD_WB_ALU;
            ctrl_pkg::CLASS_IMM: sel = ctrl_pkg::FWD_WB_IMM;
            default:             sel = ctrl_pkg::FWD_WB_LOAD;
         endcase
      end
      return sel;
   endfunction

   always_comb begin
      p0_sel = lookup(rd0_en, rd0_addr);
      p1_sel = lookup(rd1_en, rd1_addr);
   end

   // load data is not ready until the load leaves EX/MEM
   assign p0_load_use = rd0_en && ex_class == ctrl_pkg::CLASS_LOAD && ex_dst == rd0_addr;
   assign p1_load_use = rd1_en && ex_class == ctrl_pkg::CLASS_LOAD && ex_dst == rd1_addr;

   assign stall = p0_load_use | p1_load_use | branch_wait;

   //////////////////////////////
   // registered selects
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst || stall) begin
         fwd_p0_sel <= ctrl_pkg::FWD_NONE;   // bubble carries no forwards
         fwd_p1_sel <= ctrl_pkg::FWD_NONE;
      end else begin
         fwd_p0_sel <= p0_sel;
         fwd_p1_sel <= p1_sel;
      end
   end

   // a load forward always comes from a load that has left ID/EX
   property p_load_in_wb(sel);
      @(posedge clk) disable iff (rst)
         sel == ctrl_pkg::FWD_MEM_LOAD |-> wb_class == ctrl_pkg::CLASS_LOAD;
   endproperty

   a_p0_no_ex_load: assert property (p_load_in_wb(fwd_p0_sel))
      else $error("port 0 forwards a load from ID/EX");
   a_p1_no_ex_load: assert property (p_load_in_wb(fwd_p1_sel))
      else $error("port 1 forwards a load from ID/EX");

endmodule

`default_nettype wire

// File: rtl/pipeline_control.sv
`default_nettype none

`include "ctrl_params.svh"

module pipeline_control (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire logic [`CTRL_INSTR_W-1:0]  instr,      // IF/ID register
   input  wire logic                      n,
   input  wire logic                      z,
   input  wire logic                      v,
   output logic                           reg_we,
   output logic                           rd0_en,
   output logic                           rd1_en,
   output logic [`CTRL_REG_W-1:0]         rd0_addr,
   output logic [`CTRL_REG_W-1:0]         rd1_addr,
   output logic [`CTRL_REG_W-1:0]         dst_addr,
   output ctrl_pkg::alu_src_t             alu_src,
   output ctrl_pkg::dst_src_t             dst_src,
   output logic                           imm_high,
   output logic                           dm_we,
   output logic                           dm_re,
   output logic                           n_flag,
   output logic                           z_flag,
   output logic                           v_flag,
   output logic                           branch_taken,
   output logic                           stall,
   output ctrl_pkg::fwd_sel_t             fwd_p0_sel,
   output ctrl_pkg::fwd_sel_t             fwd_p1_sel
);

   ctrl_pkg::op_class_t       op_class;
   ctrl_pkg::cond_t           cond;
   logic                      flag_en;
   logic                      is_branch;
   logic                      branch_wait;
   ctrl_pkg::op_class_t       ex_class, mem_class, wb_class;
   logic [`CTRL_REG_W-1:0]    ex_dst, mem_dst, wb_dst;

   instr_decoder u_decoder (
      .instr(instr), .reg_we(reg_we), .rd0_en(rd0_en), .rd1_en(rd1_en),
      .rd0_addr(rd0_addr), .rd1_addr(rd1_addr), .dst_addr(dst_addr),
      .alu_src(alu_src), .dst_src(dst_src), .imm_high(imm_high),
      .dm_we(dm_we), .dm_re(dm_re), .flag_en(flag_en), .is_branch(is_branch),
      .op_class(op_class), .cond(cond)
   );

   flag_branch_unit u_flags (
      .clk(clk), .rst(rst), .n(n), .z(z), .v(v),
      .flag_en(flag_en), .is_branch(is_branch), .cond(cond), .stall(stall),
      .n_flag(n_flag), .z_flag(z_flag), .v_flag(v_flag),
      .branch_taken(branch_taken), .branch_wait(branch_wait)
   );

   stage_tracker u_tracker (
      .clk(clk), .rst(rst), .stall(stall), .op_class(op_class), .dst_addr(dst_addr),
      .ex_class(ex_class), .mem_class(mem_class), .wb_class(wb_class),
      .ex_dst(ex_dst), .mem_dst(mem_dst), .wb_dst(wb_dst)
   );

   forward_select u_forward (
      .clk(clk), .rst(rst), .rd0_en(rd0_en), .rd1_en(rd1_en),
      .rd0_addr(rd0_addr), .rd1_addr(rd1_addr),
      .ex_class(ex_class), .mem_class(mem_class), .wb_class(wb_class),
      .ex_dst(ex_dst), .mem_dst(mem_dst), .wb_dst(wb_dst),
      .branch_wait(branch_wait), .stall(stall),
      .fwd_p0_sel(fwd_p0_sel), .fwd_p1_sel(fwd_p1_sel)
   );

endmodule

`default_nettype wire

// File: verif/tb_pipeline_control.sv
`default_nettype none

`include "ctrl_params.svh"

module tb_pipeline_control;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int STALL_LIMIT  = 8;     // cycles a held instruction may wait
   localparam int RANDOM_COUNT = 400;
   localparam logic [`CTRL_INSTR_W-1:0] NOP_WORD = {ctrl_pkg::CALL, 12'h000};

   logic                      clk;
   logic                      rst;
   logic [`CTRL_INSTR_W-1:0]  instr;
   logic                      n, z, v;
   logic                      reg_we, rd0_en, rd1_en;
   logic [`CTRL_REG_W-1:0]    rd0_addr, rd1_addr, dst_addr;
   ctrl_pkg::alu_src_t        alu_src;
   ctrl_pkg::dst_src_t        dst_src;
   logic                      imm_high, dm_we, dm_re;
   logic                      n_flag, z_flag, v_flag;
   logic                      branch_taken;
   logic                      stall;
   ctrl_pkg::fwd_sel_t        fwd_p0_sel, fwd_p1_sel;

   pipeline_control u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////
   // expected decode
   //////////////////////////////

   ctrl_pkg::opcode_t         f_op;
   ctrl_pkg::cond_t           f_cond;
   logic [`CTRL_REG_W-1:0]    f_dst, f_src0, f_src1, e_rd1_addr;
   logic [9:0]                e_dec;   // class, then the eight control bits below
   logic [1:0]                e_class;
   ctrl_pkg::alu_src_t        e_alu_src;
   logic                      e_reg_we, e_rd0_en, e_rd1_en, e_rd1_dst;
   logic                      e_dm_we, e_dm_re, e_flag_en, e_branch;
   logic                      e_wait, e_lu0, e_lu1, e_stall, e_taken;

   assign f_op   = ctrl_pkg::opcode_t'(instr[15:12]);
   assign f_dst  = instr[11:8];
   assign f_src0 = instr[7:4];
   assign f_src1 = instr[3:0];
   assign f_cond = ctrl_pkg::cond_t'(instr[10:8]);

   // reg_we rd0_en rd1_en rd1_at_dst | dm_we dm_re flag_en branch
   always_comb begin
      case (f_op)
         ctrl_pkg::ADD, ctrl_pkg::SUB, ctrl_pkg::NAND, ctrl_pkg::XOR:
            e_dec = {ctrl_pkg::CLASS_ALU, 8'b1110_0010};
         ctrl_pkg::CMP:                e_dec = {ctrl_pkg::CLASS_NONE, 8'b0110_0010};
         ctrl_pkg::INC:                e_dec = {ctrl_pkg::CLASS_ALU, 8'b1011_0010};
         ctrl_pkg::SRA, ctrl_pkg::SRL, ctrl_pkg::SLL:
            e_dec = {ctrl_pkg::CLASS_ALU, 8'b1100_0000};
         ctrl_pkg::LW:                 e_dec = {ctrl_pkg::CLASS_LOAD, 8'b1100_0100};
         ctrl_pkg::SW:                 e_dec = {ctrl_pkg::CLASS_NONE, 8'b0111_1000};
         ctrl_pkg::LHB, ctrl_pkg::LLB: e_dec = {ctrl_pkg::CLASS_IMM, 8'b1011_0000};
         ctrl_pkg::B:                  e_dec = {ctrl_pkg::CLASS_NONE, 8'b0000_0001};
         default:                      e_dec = '0;   // CALL, RET
      endcase
   end

   // operand source the ALU needs for each opcode
   always_comb begin
      case (f_op)
         ctrl_pkg::ADD, ctrl_pkg::SUB, ctrl_pkg::NAND, ctrl_pkg::XOR, ctrl_pkg::CMP:
            e_alu_src = ctrl_pkg::SRC_REG_REG;
         ctrl_pkg::INC:                e_alu_src = ctrl_pkg::SRC_REG_IMM_S;
         ctrl_pkg::SRA, ctrl_pkg::SRL, ctrl_pkg::SLL:
            e_alu_src = ctrl_pkg::SRC_REG_IMM;
         ctrl_pkg::LW:                 e_alu_src = ctrl_pkg::SRC_LOAD_ADDR;
         ctrl_pkg::SW:                 e_alu_src = ctrl_pkg::SRC_STORE_ADDR;
         default:                      e_alu_src = ctrl_pkg::SRC_NONE;
      endcase
   end

   assign {e_class, e_reg_we, e_rd0_en, e_rd1_en, e_rd1_dst,
           e_dm_we, e_dm_re, e_flag_en, e_branch} = e_dec;
   assign e_rd1_addr = e_rd1_dst ? f_dst : f_src1;

   //////////////////////////////
   // pipeline model
   //////////////////////////////

   logic [1:0]                m_class [3];   // ID/EX, EX/MEM, MEM/WB
   logic [`CTRL_REG_W-1:0]    m_dst [3];
   logic                      m_pending, m_n, m_z, m_v;
   ctrl_pkg::fwd_sel_t        m_fwd0, m_fwd1;
   logic                      last_stall;    // stall as seen at the last edge

   function automatic logic cond_holds(input ctrl_pkg::cond_t c, input logic fn,
                                       input logic fz, input logic fv);
      case (c)
         ctrl_pkg::EQ: return fz;
         ctrl_pkg::LT: return fn && !fv;
         ctrl_pkg::GT: return !fn && !fv && !fz;
         ctrl_pkg::OV: return fv;
         ctrl_pkg::NE: return !fz;
         ctrl_pkg::GE: return fz || (!fn && !fv);
         ctrl_pkg::LE: return fz || (fn && !fv);
         default:      return 1'b1;
      endcase
   endfunction

   // nearest producer wins, ID/EX first
   function automatic ctrl_pkg::fwd_sel_t expected_fwd(input logic en,
                                                       input logic [`CTRL_REG_W-1:0] addr);
      ctrl_pkg::fwd_sel_t sel;
      sel = ctrl_pkg::FWD_NONE;
      if (en && m_class[0] != ctrl_pkg::CLASS_NONE && m_dst[0] == addr)
         sel = m_class[0] == ctrl_pkg::CLASS_ALU ? ctrl_pkg::FWD_EX_ALU :
               m_class[0] == ctrl_pkg::CLASS_IMM ? ctrl_pkg::FWD_EX_IMM : ctrl_pkg::FWD_NONE;
      else if (en && m_class[1] != ctrl_pkg::CLASS_NONE && m_dst[1] == addr)
         sel = m_class[1] == ctrl_pkg::CLASS_ALU ? ctrl_pkg::FWD_MEM_ALU :
               m_class[1] == ctrl_pkg::CLASS_IMM ? ctrl_pkg::FWD_MEM_IMM : ctrl_pkg::FWD_MEM_LOAD;
      else if (en && m_class[2] != ctrl_pkg::CLASS_NONE && m_dst[2] == addr)
         sel = m_class[2] == ctrl_pkg::CLASS_ALU ? ctrl_pkg::FWD_WB_ALU :
               m_class[2] == ctrl_pkg::CLASS_IMM ? ctrl_pkg::FWD_WB_IMM : ctrl_pkg::FWD_WB_LOAD;
      return sel;
   endfunction

   assign e_wait  = e_branch && m_pending;
   assign e_lu0   = e_rd0_en && m_class[0] == ctrl_pkg::CLASS_LOAD && m_dst[0] == f_src0;
   assign e_lu1   = e_rd1_en && m_class[0] == ctrl_pkg::CLASS_LOAD && m_dst[0] == e_rd1_addr;
   assign e_stall = e_wait || e_lu0 || e_lu1;
   assign e_taken = e_branch && cond_holds(f_cond, m_n, m_z, m_v) &&
                    (!m_pending || f_cond == ctrl_pkg::TRUE);   // no branch on stale flags

   always_ff @(posedge clk) begin
      last_stall <= stall;
      m_dst[0]   <= f_dst;
      m_dst[1]   <= m_dst[0];
      m_dst[2]   <= m_dst[1];
      if (rst) begin
         m_pending <= 1'b0;
         {m_n, m_z, m_v} <= 3'b000;
         m_class <= '{default: ctrl_pkg::CLASS_NONE};
         m_fwd0 <= ctrl_pkg::FWD_NONE;
         m_fwd1 <= ctrl_pkg::FWD_NONE;
      end else begin
         m_pending <= e_flag_en && !e_stall;
         if (m_pending)
            {m_n, m_z, m_v} <= {n, z, v};   // EX result of the setter
         m_class[0] <= e_stall ? ctrl_pkg::CLASS_NONE : e_class;
         m_class[1] <= m_class[0];
         m_class[2] <= m_class[1];
         m_fwd0 <= e_stall ? ctrl_pkg::FWD_NONE : expected_fwd(e_rd0_en, f_src0);
         m_fwd1 <= e_stall ? ctrl_pkg::FWD_NONE : expected_fwd(e_rd1_en, e_rd1_addr);
      end
   end

   //////////////////////////////
   // checks
   //////////////////////////////

   task automatic stop_failed();
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic value_error(input string msg);
      $display("** Error at time %0t: %s (instr %h)", $time, msg, instr);
      stop_failed();
   endtask

   a_decode_en: assert property (@(posedge clk)
      {reg_we, rd0_en, rd1_en, dm_we, dm_re} == {e_reg_we, e_rd0_en, e_rd1_en, e_dm_we, e_dm_re})
      else value_error("decoded enables wrong");
   a_decode_addr: assert property (@(posedge clk)
      (!e_rd0_en || rd0_addr == f_src0) && (!e_rd1_en || rd1_addr == e_rd1_addr) &&
      dst_addr == f_dst)
      else value_error("read or destination address wrong");
   a_decode_alu_src: assert property (@(posedge clk) alu_src == e_alu_src)
      else value_error("ALU source wrong");
   a_decode_dst: assert property (@(posedge clk)
      (e_class != ctrl_pkg::CLASS_IMM ||
       (dst_src == ctrl_pkg::DST_IMM_BYTE && imm_high == (f_op == ctrl_pkg::LHB))) &&
      (e_class != ctrl_pkg::CLASS_ALU || dst_src == ctrl_pkg::DST_ALU) &&
      (f_op != ctrl_pkg::LW || dst_src == ctrl_pkg::DST_MEM))
      else value_error("write-back source or byte select wrong");

   a_reset: assert property (@(posedge clk)
      rst |=> !stall && !n_flag && !z_flag && !v_flag &&
              fwd_p0_sel == ctrl_pkg::FWD_NONE && fwd_p1_sel == ctrl_pkg::FWD_NONE)
      else value_error("state not cleared by reset");

   a_stall: assert property (@(posedge clk) disable iff (rst) stall == e_stall)
      else value_error("stall wrong");
   a_flags_load: assert property (@(posedge clk) disable iff (rst)
      m_pending |=> {n_flag, z_flag, v_flag} == $past({n, z, v}))
      else value_error("flags did not load the EX result");
   a_flags_hold: assert property (@(posedge clk) disable iff (rst)
      !m_pending |=> $stable({n_flag, z_flag, v_flag}))
      else value_error("flags changed without a setter in EX");
   a_taken: assert property (@(posedge clk) disable iff (rst) branch_taken == e_taken)
      else value_error("branch decision wrong");
   a_wait_once: assert property (@(posedge clk) disable iff (rst) e_wait |=> !stall)
      else value_error("branch stalled longer than one cycle");

   a_fwd: assert property (@(posedge clk) disable iff (rst)
      fwd_p0_sel == m_fwd0 && fwd_p1_sel == m_fwd1)
      else value_error("forward select wrong");
   a_bubble: assert property (@(posedge clk) disable iff (rst)
      stall |=> fwd_p0_sel == ctrl_pkg::FWD_NONE && fwd_p1_sel == ctrl_pkg::FWD_NONE)
      else value_error("forward select active after a stalled cycle");
   a_load_p0: assert property (@(posedge clk) disable iff (rst)
      $past(e_lu0, 2) |-> fwd_p0_sel == ctrl_pkg::FWD_MEM_LOAD)
      else value_error("port 0 load-use not forwarded from EX/MEM");
   a_load_p1: assert property (@(posedge clk) disable iff (rst)
      $past(e_lu1, 2) |-> fwd_p1_sel == ctrl_pkg::FWD_MEM_LOAD)
      else value_error("port 1 load-use not forwarded from EX/MEM");

   //////////////////////////////
   // stimulus
   //////////////////////////////

   function automatic logic [`CTRL_INSTR_W-1:0] encode(input ctrl_pkg::opcode_t op,
                                                       input logic [`CTRL_REG_W-1:0] d,
                                                       input logic [`CTRL_REG_W-1:0] s0,
                                                       input logic [`CTRL_REG_W-1:0] s1);
      return {op, d, s0, s1};
   endfunction

   task automatic drive_flags();
      logic [31:0] r;
      r = $urandom();
      n = r[0];
      z = r[1];
      v = r[2];
   endtask

   // called at a falling edge, returns at the falling edge after acceptance
   task automatic issue(input logic [`CTRL_INSTR_W-1:0] word);
      int waited;
      waited = 0;
      instr = word;
      drive_flags();
      @(negedge clk);
      while (last_stall && waited < STALL_LIMIT) begin
         waited++;
         drive_flags();   // instr held
         @(negedge clk);
      end
      if (last_stall) begin
         $display("timeout: instruction %h still stalled after %0d cycles", word, waited);
         stop_failed();
      end
   endtask

   initial begin
      logic [31:0] rnd;
      void'($urandom(32'had13));
      rst   = 1'b1;
      instr = NOP_WORD;
      n     = 1'b0;
      z     = 1'b0;
      v     = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int op = 0; op < 16; op++) begin   // every opcode once
         rnd = $urandom();
         issue({op[3:0], rnd[11:0]});
      end

      issue(encode(ctrl_pkg::ADD, 4'd1, 4'd2, 4'd3));
      issue(encode(ctrl_pkg::SLL, 4'd4, 4'd5, 4'd1));
      issue(encode(ctrl_pkg::SRA, 4'd6, 4'd7, 4'd2));
      issue(encode(ctrl_pkg::CMP, 4'd0, 4'd2, 4'd3));
      issue(encode(ctrl_pkg::SRL, 4'd6, 4'd6, 4'd3));

      // setter then branch, then the same branch on settled flags
      for (int c = 0; c < 8; c++) begin
         for (int k = 0; k < 4; k++) begin
            issue(encode(ctrl_pkg::SUB, 4'd8, 4'd9, 4'd10));
            issue(encode(ctrl_pkg::B, {1'b0, c[2:0]}, 4'd0, 4'd0));
            issue(encode(ctrl_pkg::B, {1'b0, c[2:0]}, 4'd0, 4'd0));
         end
      end

      for (int gap = 0; gap < 3; gap++) begin
         for (int p = 0; p < 2; p++) begin
            for (int c = 0; c < 5; c++) begin
               issue(p == 0 ? encode(ctrl_pkg::ADD, 4'd5, 4'd1, 4'd2) :
                              encode(ctrl_pkg::LLB, 4'd5, 4'd0, 4'd0));
               for (int j = 0; j < gap; j++)
                  issue(NOP_WORD);
               case (c)
                  0: issue(encode(ctrl_pkg::ADD, 4'd1, 4'd5, 4'd2));
                  1: issue(encode(ctrl_pkg::XOR, 4'd1, 4'd2, 4'd5));
                  2: issue(encode(ctrl_pkg::INC, 4'd5, 4'd5, 4'd0));   // port 0 unread
                  3: issue(encode(ctrl_pkg::SW, 4'd5, 4'd3, 4'd0));
                  default: issue(encode(ctrl_pkg::LHB, 4'd5, 4'd5, 4'd0));
               endcase
            end
         end
      end

      for (int gap = 0; gap < 2; gap++) begin   // load-use, then a later reader
         issue(encode(ctrl_pkg::LW, 4'd7, 4'd3, 4'd0));
         for (int j = 0; j < gap; j++)
            issue(NOP_WORD);
         issue(encode(ctrl_pkg::ADD, 4'd1, 4'd7, 4'd7));
         issue(encode(ctrl_pkg::SW, 4'd7, 4'd7, 4'd0));
      end

      // registers r0..r7 only, so hazards are frequent
      for (int i = 0; i < RANDOM_COUNT; i++) begin
         rnd = $urandom();
         issue({rnd[15:12], 1'b0, rnd[10:8], 1'b0, rnd[6:4], 1'b0, rnd[2:0]});
      end
      for (int i = 0; i < 4; i++)
         issue(NOP_WORD);

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/flag_branch_unit.sv
rtl/stage_tracker.sv
rtl/forward_select.sv
rtl/pipeline_control.sv
verif/tb_pipeline_control.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_pipeline_control
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
